// File: logic/decodePkg.sv
// Shared types, opcode map and field positions for the decode stage
// Opcode values are local to this core; any code not listed here is illegal
// Field positions assume the fixed 40-bit instruction word

package decodePkg;

	// ==============================
	// Types
	// ==============================
	typedef logic [39:0] instrT;
	typedef logic [6:0]  opcodeT;
	typedef logic [1:0]  precT;
	typedef logic [5:0]  regNumT;
	typedef logic [63:0] immT;
	typedef logic [2:0]  unitT;

	// Precision 11 selects the full 64-bit width
	localparam precT PREC_DEFAULT = 2'b11;

	// Functional-unit codes
	localparam unitT UNIT_ALU    = 3'd0;
	localparam unitT UNIT_MUL    = 3'd1;
	localparam unitT UNIT_DIV    = 3'd2;
	localparam unitT UNIT_FPU    = 3'd3;
	localparam unitT UNIT_MEM    = 3'd4;
	localparam unitT UNIT_BRANCH = 3'd5;
	localparam unitT UNIT_SYS    = 3'd6;
	localparam unitT UNIT_NONE   = 3'd7;

	// ==============================
	// Opcodes
	// ==============================
	// Scalar codes live below 64; a vector twin sits at scalar code plus 64
	localparam opcodeT OP_SYS    = 7'd0;
	localparam opcodeT OP_R2     = 7'd2;
	localparam opcodeT OP_ADDI   = 7'd4;
	localparam opcodeT OP_SUBFI  = 7'd5;
	localparam opcodeT OP_CMPI   = 7'd6;
	localparam opcodeT OP_MULI   = 7'd7;
	localparam opcodeT OP_DIVI   = 7'd8;
	localparam opcodeT OP_ANDI   = 7'd9;
	localparam opcodeT OP_ORI    = 7'd10;
	localparam opcodeT OP_EORI   = 7'd11;
	localparam opcodeT OP_SLTI   = 7'd12;
	localparam opcodeT OP_FLT3   = 7'd13;
	localparam opcodeT OP_SHIFT  = 7'd14;
	localparam opcodeT OP_CSR    = 7'd16;
	localparam opcodeT OP_MOV    = 7'd17;
	localparam opcodeT OP_LDAX   = 7'd18;
	localparam opcodeT OP_ADDSI  = 7'd20;
	localparam opcodeT OP_ORSI   = 7'd21;
	localparam opcodeT OP_ANDSI  = 7'd22;
	localparam opcodeT OP_EORSI  = 7'd23;
	localparam opcodeT OP_BSR    = 7'd32;
	localparam opcodeT OP_JSR    = 7'd33;
	localparam opcodeT OP_FENCE  = 7'd40;
	localparam opcodeT OP_NOP    = 7'd41;
	localparam opcodeT OP_PUSH   = 7'd42;
	localparam opcodeT OP_POP    = 7'd43;
	localparam opcodeT OP_ENTER  = 7'd44;
	localparam opcodeT OP_LEAVE  = 7'd45;
	localparam opcodeT OP_ATOM   = 7'd46;
	localparam opcodeT OP_PFXA32 = 7'd48;
	localparam opcodeT OP_PFXB32 = 7'd49;
	localparam opcodeT OP_PFXC32 = 7'd50;
	localparam opcodeT OP_QFEXT  = 7'd52;
	localparam opcodeT OP_REGC   = 7'd53;
	localparam opcodeT OP_VEC    = 7'd54;
	localparam opcodeT OP_VECZ   = 7'd55;
	localparam opcodeT OP_VADDI  = 7'd68;
	localparam opcodeT OP_VCMPI  = 7'd70;
	localparam opcodeT OP_VMULI  = 7'd71;
	localparam opcodeT OP_VDIVI  = 7'd72;
	localparam opcodeT OP_VANDI  = 7'd73;
	localparam opcodeT OP_VORI   = 7'd74;
	localparam opcodeT OP_VEORI  = 7'd75;
	localparam opcodeT OP_VSHIFT = 7'd78;
	localparam opcodeT OP_VADDSI = 7'd84;
	localparam opcodeT OP_VORSI  = 7'd85;
	localparam opcodeT OP_VANDSI = 7'd86;
	localparam opcodeT OP_VEORSI = 7'd87;

	// ==============================
	// Field positions
	// ==============================
	localparam int OPC_LSB     = 0;
	localparam int OPC_W       = 7;
	localparam int REG_W       = 6;
	localparam int RD_LSB      = 7;
	localparam int RS1_LSB     = 13;
	localparam int RS2_LSB     = 19;
	localparam int RS3_LSB     = 25;
	localparam int PREC_W      = 2;
	localparam int PREC_R2_LSB = 31;
	localparam int PREC_LI_LSB = 19;
	localparam int PREC_SI_LSB = 16;
	localparam int PREC_SH_LSB = 34;
	localparam int LIMM_LSB    = 21;
	localparam int LIMM_W      = 19;
	localparam int SIMM_LSB    = 18;
	localparam int SIMM_W      = 22;
	localparam int SHAMT_LSB   = 25;
	localparam int SHAMT_W     = 6;
	localparam int IMM_W       = 64;

	// Long-immediate form, scalar and vector
	function automatic logic isLongImm(opcodeT op);
		case (op)
			OP_ADDI, OP_VADDI, OP_SUBFI, OP_CMPI, OP_VCMPI, OP_MULI, OP_VMULI,
			OP_DIVI, OP_VDIVI, OP_ANDI, OP_VANDI, OP_ORI, OP_VORI, OP_EORI,
			OP_VEORI, OP_SLTI:
				isLongImm = 1'b1;
			default:
				isLongImm = 1'b0;
		endcase
	endfunction

	// Short-immediate form, where the destination doubles as the source
	function automatic logic isShortImm(opcodeT op);
		case (op)
			OP_ADDSI, OP_VADDSI, OP_ORSI, OP_VORSI, OP_ANDSI, OP_VANDSI,
			OP_EORSI, OP_VEORSI:
				isShortImm = 1'b1;
			default:
				isShortImm = 1'b0;
		endcase
	endfunction

	// Shift form with an inline shift amount
	function automatic logic isShift(opcodeT op);
		isShift = (op == OP_SHIFT) || (op == OP_VSHIFT);
	endfunction

endpackage

// File: logic/decodePrec.sv
// Combinational precision decoder, zero cycles from instr to prec
// Opcodes without a precision field, and illegal ones, report 64 bits

module decodePrec
(
	input  decodePkg::instrT instr,
	output decodePkg::precT  prec
);
	import decodePkg::*;

	// Opcode sits in the low bits of every form
	opcodeT opcode;

	// Candidate precision fields, one per instruction form
	precT precR2;
	precT precLong;
	precT precShort;
	precT precShift;

	assign opcode = instr[OPC_LSB +: OPC_W];

	// ==============================
	// Field extraction
	// ==============================
	// Register-register form keeps its precision above the third source
	assign precR2 = instr[PREC_R2_LSB +: PREC_W];

	// Long-immediate form places it just under the immediate
	assign precLong = instr[PREC_LI_LSB +: PREC_W];

	// Short-immediate form has no rs1 field, so precision sits lower
	assign precShort = instr[PREC_SI_LSB +: PREC_W];

	// Shift and three-operand float share one position
	assign precShift = instr[PREC_SH_LSB +: PREC_W];

	// ==============================
	// Field select by opcode
	// ==============================
	always_comb
	begin
		// Full width unless a form below says otherwise
		prec = PREC_DEFAULT;
		if (opcode == OP_R2)
		begin
			prec = precR2;
		end
		else if (isLongImm(opcode))
		begin
			prec = precLong;
		end
		else if (isShortImm(opcode))
		begin
			prec = precShort;
		end
		else if (isShift(opcode) || opcode == OP_FLT3)
		begin
			prec = precShift;
		end
		// SYS, CSR, MOV, LDAX, branches, prefixes and memory ops fall through
	end

endmodule

// File: logic/decodeRegs.sv
// Combinational register-field decoder
// Fields that an opcode does not use read as register 0
// Short-immediate forms reuse rd as the first source

module decodeRegs
(
	input  decodePkg::instrT  instr,
	output decodePkg::regNumT rd,
	output decodePkg::regNumT rs1,
	output decodePkg::regNumT rs2,
	output decodePkg::regNumT rs3,
	output logic              regWrite
);
	import decodePkg::*;

	opcodeT opcode;

	// Raw fields before masking
	regNumT rdField;
	regNumT rs1Field;
	regNumT rs2Field;
	regNumT rs3Field;

	// Form flags
	logic shortImm;
	logic hasRs2;
	logic hasRs3;

	assign opcode   = instr[OPC_LSB +: OPC_W];
	assign rdField  = instr[RD_LSB +: REG_W];
	assign rs1Field = instr[RS1_LSB +: REG_W];
	assign rs2Field = instr[RS2_LSB +: REG_W];
	assign rs3Field = instr[RS3_LSB +: REG_W];

	assign shortImm = isShortImm(opcode);

	// ==============================
	// Register write and source use
	// ==============================
	always_comb
	begin
		case (opcode)
			OP_R2, OP_FLT3, OP_MOV, OP_CSR, OP_LDAX:
				regWrite = 1'b1;
			default:
				regWrite = isShift(opcode) || isLongImm(opcode) || shortImm;
		endcase
	end

	// Only the register and float forms carry a second source
	assign hasRs2 = (opcode == OP_R2) || (opcode == OP_FLT3);

	// Fused float ops are the only three-source instructions
	assign hasRs3 = (opcode == OP_FLT3);

	// ==============================
	// Field masking
	// ==============================
	// rd is meaningful only when the instruction writes it
	assign rd = regWrite ? rdField : '0;

	// The rs1 field holds immediate bits in short forms, so rd feeds rs1 there
	assign rs1 = !regWrite ? '0 :
		shortImm ? rdField : rs1Field;

	assign rs2 = hasRs2 ? rs2Field : '0;
	assign rs3 = hasRs3 ? rs3Field : '0;

endmodule

// File: logic/decodeImm.sv
// Combinational immediate builder, always 64 bits wide
// Long and short forms are signed, the shift amount is unsigned

module decodeImm
(
	input  decodePkg::instrT instr,
	output decodePkg::immT   imm,
	output logic             hasImm
);
	import decodePkg::*;

	opcodeT opcode;

	// Raw immediate fields of each form
	logic [LIMM_W-1:0]  longField;
	logic [SIMM_W-1:0]  shortField;
	logic [SHAMT_W-1:0] shamtField;

	// Fields after extension to full width
	immT longExt;
	immT shortExt;
	immT shamtExt;

	assign opcode     = instr[OPC_LSB +: OPC_W];
	assign longField  = instr[LIMM_LSB +: LIMM_W];
	assign shortField = instr[SIMM_LSB +: SIMM_W];
	assign shamtField = instr[SHAMT_LSB +: SHAMT_W];

	// ==============================
	// Extension
	// ==============================
	// Replicate the top bit of the 19-bit field
	assign longExt = {{(IMM_W-LIMM_W){longField[LIMM_W-1]}}, longField};

	// Same for the 22-bit short field
	assign shortExt = {{(IMM_W-SIMM_W){shortField[SIMM_W-1]}}, shortField};

	// Shift counts are never negative
	assign shamtExt = {{(IMM_W-SHAMT_W){1'b0}}, shamtField};

	// ==============================
	// Select by form
	// ==============================
	always_comb
	begin
		imm    = '0;
		hasImm = 1'b0;
		if (isLongImm(opcode))
		begin
			imm    = longExt;
			hasImm = 1'b1;
		end
		else if (isShortImm(opcode))
		begin
			imm    = shortExt;
			hasImm = 1'b1;
		end
		else if (isShift(opcode))
		begin
			imm    = shamtExt;
			hasImm = 1'b1;
		end
	end

endmodule

// File: logic/decodeUnitSel.sv
// Combinational functional-unit selector
// Unknown opcodes map to UNIT_NONE and raise illegal
// Prefix opcodes are steered to the system unit without merging

module decodeUnitSel
(
	input  decodePkg::instrT instr,
	output decodePkg::unitT  unit,
	output logic             vector,
	output logic             illegal
);
	import decodePkg::*;

	opcodeT opcode;

	assign opcode = instr[OPC_LSB +: OPC_W];

	// ==============================
	// Unit steering
	// ==============================
	always_comb
	begin
		case (opcode)
			OP_MULI, OP_VMULI:
				unit = UNIT_MUL;
			OP_DIVI, OP_VDIVI:
				unit = UNIT_DIV;
			OP_FLT3:
				unit = UNIT_FPU;
			OP_LDAX, OP_PUSH, OP_POP, OP_ENTER, OP_LEAVE, OP_ATOM:
				unit = UNIT_MEM;
			OP_BSR, OP_JSR:
				unit = UNIT_BRANCH;
			OP_SYS, OP_CSR, OP_FENCE, OP_NOP, OP_PFXA32, OP_PFXB32, OP_PFXC32,
			OP_QFEXT, OP_REGC, OP_VEC, OP_VECZ:
				unit = UNIT_SYS;
			// Plain integer work goes to the ALU
			OP_R2, OP_MOV, OP_ADDI, OP_VADDI, OP_SUBFI, OP_CMPI, OP_VCMPI,
			OP_ANDI, OP_VANDI, OP_ORI, OP_VORI, OP_EORI, OP_VEORI, OP_SLTI,
			OP_ADDSI, OP_VADDSI, OP_ORSI, OP_VORSI, OP_ANDSI, OP_VANDSI,
			OP_EORSI, OP_VEORSI, OP_SHIFT, OP_VSHIFT:
				unit = UNIT_ALU;
			default:
				unit = UNIT_NONE;
		endcase
	end

	// Nothing legal is ever steered to UNIT_NONE
	assign illegal = (unit == UNIT_NONE);

	// ==============================
	// Vector flag
	// ==============================
	always_comb
	begin
		case (opcode)
			OP_VADDI, OP_VCMPI, OP_VMULI, OP_VDIVI, OP_VANDI, OP_VORI, OP_VEORI,
			OP_VADDSI, OP_VORSI, OP_VANDSI, OP_VEORSI, OP_VSHIFT, OP_VEC, OP_VECZ:
				vector = 1'b1;
			default:
				vector = 1'b0;
		endcase
	end

endmodule

// File: logic/decodeStage.sv
// Decode stage top, one cycle from instrValid to decValid
// No stall input; a new instruction may arrive every cycle
// Field registers hold their last value while instrValid is low

module decodeStage
(
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  decodePkg::instrT   instr,
	output logic               decValid,
	output decodePkg::precT    decPrec,
	output decodePkg::regNumT  decRd,
	output decodePkg::regNumT  decRs1,
	output decodePkg::regNumT  decRs2,
	output decodePkg::regNumT  decRs3,
	output logic               decRegWrite,
	output decodePkg::immT     decImm,
	output logic               decHasImm,
	output decodePkg::unitT    decUnit,
	output logic               decVector,
	output logic               decIllegal
);
	import decodePkg::*;

	// Combinational decoder results for the current instr
	precT   nxtPrec;
	regNumT nxtRd;
	regNumT nxtRs1;
	regNumT nxtRs2;
	regNumT nxtRs3;
	logic   nxtRegWrite;
	immT    nxtImm;
	logic   nxtHasImm;
	unitT   nxtUnit;
	logic   nxtVector;
	logic   nxtIllegal;

	// ==============================
	// Decoders
	// ==============================
	decodePrec u_prec (.instr(instr), .prec(nxtPrec));

	decodeRegs u_regs
	(
		.instr(instr), .rd(nxtRd), .rs1(nxtRs1), .rs2(nxtRs2), .rs3(nxtRs3),
		.regWrite(nxtRegWrite)
	);

	decodeImm u_imm (.instr(instr), .imm(nxtImm), .hasImm(nxtHasImm));

	decodeUnitSel u_unitSel
	(
		.instr(instr), .unit(nxtUnit), .vector(nxtVector), .illegal(nxtIllegal)
	);

	// ==============================
	// Output register
	// ==============================
	// Valid tracks the strobe every cycle
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			decValid <= 1'b0;
		else
			decValid <= instrValid;
	end

	// Fields load only with a valid instruction
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			decPrec     <= '0;
			decRd       <= '0;
			decRs1      <= '0;
			decRs2      <= '0;
			decRs3      <= '0;
			decRegWrite <= 1'b0;
			decImm      <= '0;
			decHasImm   <= 1'b0;
			decUnit     <= '0;
			decVector   <= 1'b0;
			decIllegal  <= 1'b0;
		end
		else if (instrValid)
		begin
			decPrec     <= nxtPrec;
			decRd       <= nxtRd;
			decRs1      <= nxtRs1;
			decRs2      <= nxtRs2;
			decRs3      <= nxtRs3;
			// An illegal instruction must never reach the register file
			decRegWrite <= nxtRegWrite & ~nxtIllegal;
			decImm      <= nxtImm;
			decHasImm   <= nxtHasImm;
			decUnit     <= nxtUnit;
			decVector   <= nxtVector;
			decIllegal  <= nxtIllegal;
		end
	end

endmodule

// File: testbench/decodeStage_assert.sv
// Concurrent checks on the decode stage outputs, bound into decodeStage
// All properties are disabled while arstN is low

module decodeStageAssert
(
	input logic             clk,
	input logic             arstN,
	input logic             instrValid,
	input decodePkg::instrT instr,
	input logic             decValid,
	input logic             decRegWrite,
	input logic             decHasImm,
	input decodePkg::unitT  decUnit,
	input logic             decIllegal
);
	import decodePkg::*;

	opcodeT opcode;
	logic   longImm;

	assign opcode  = instr[OPC_LSB +: OPC_W];
	assign longImm = opcode inside {OP_ADDI, OP_VADDI, OP_SUBFI, OP_CMPI, OP_VCMPI, OP_MULI,
		OP_VMULI, OP_DIVI, OP_VDIVI, OP_ANDI, OP_VANDI, OP_ORI, OP_VORI, OP_EORI, OP_VEORI,
		OP_SLTI};

	// ==============================
	// Properties
	// ==============================
	// decValid is the strobe delayed by one cycle
	validFollowsStrobe: assert property (@(posedge clk) disable iff (!arstN)
		decValid == $past(instrValid))
		else $error("decValid does not follow instrValid by one cycle");

	// A bad opcode never writes a register
	illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
		decIllegal |-> !decRegWrite)
		else $error("decRegWrite set together with decIllegal");

	illegalNoUnit: assert property (@(posedge clk) disable iff (!arstN)
		decIllegal |-> decUnit == UNIT_NONE)
		else $error("decIllegal set without UNIT_NONE");

	// Long forms always carry an immediate on the next cycle
	longHasImm: assert property (@(posedge clk) disable iff (!arstN)
		instrValid && longImm |=> decHasImm)
		else $error("long-immediate opcode decoded without decHasImm");

endmodule

bind decodeStage decodeStageAssert u_assert
(
	.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
	.decValid(decValid), .decRegWrite(decRegWrite), .decHasImm(decHasImm),
	.decUnit(decUnit), .decIllegal(decIllegal)
);

// File: testbench/decodeStageTb.sv
// Directed testbench for decodeStage with its own reference model of the opcode rules
// Stimulus is applied 1 time unit after each rising edge and sampled at the same point
// Every wait on decValid is bounded, so a stuck DUT cannot hang the run

module decodeStageTb;
	import decodePkg::*;

	// ==============================
	// Constants and DUT signals
	// ==============================
	localparam int WAIT_LIMIT   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int STREAM_LEN   = 200;

	logic   clk;
	logic   arstN;
	logic   instrValid;
	instrT  instr;
	logic   decValid;
	precT   decPrec;
	regNumT decRd;
	regNumT decRs1;
	regNumT decRs2;
	regNumT decRs3;
	logic   decRegWrite;
	immT    decImm;
	logic   decHasImm;
	unitT   decUnit;
	logic   decVector;
	logic   decIllegal;

	// Expected register contents, held between valid instructions like the DUT
	precT   expPrec;
	regNumT expRd;
	regNumT expRs1;
	regNumT expRs2;
	regNumT expRs3;
	logic   expRegWrite;
	immT    expImm;
	logic   expHasImm;
	unitT   expUnit;
	logic   expVector;
	logic   expIllegal;

	int     errors;
	// Defined opcodes, collected during the unit scan and reused by the stream
	opcodeT legalOps[$];

	decodeStage i_dut
	(
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.decValid(decValid), .decPrec(decPrec), .decRd(decRd), .decRs1(decRs1),
		.decRs2(decRs2), .decRs3(decRs3), .decRegWrite(decRegWrite), .decImm(decImm),
		.decHasImm(decHasImm), .decUnit(decUnit), .decVector(decVector),
		.decIllegal(decIllegal)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic logic longForm(opcodeT op);
		return op inside {OP_ADDI, OP_VADDI, OP_SUBFI, OP_CMPI, OP_VCMPI, OP_MULI, OP_VMULI,
			OP_DIVI, OP_VDIVI, OP_ANDI, OP_VANDI, OP_ORI, OP_VORI, OP_EORI, OP_VEORI, OP_SLTI};
	endfunction

	function automatic logic shortForm(opcodeT op);
		return op inside {OP_ADDSI, OP_VADDSI, OP_ORSI, OP_VORSI, OP_ANDSI, OP_VANDSI,
			OP_EORSI, OP_VEORSI};
	endfunction

	function automatic logic shiftForm(opcodeT op);
		return op inside {OP_SHIFT, OP_VSHIFT};
	endfunction

	// Every name starting with OP_V, including the vector prefix opcodes
	function automatic logic vectorOp(opcodeT op);
		return op inside {OP_VADDI, OP_VCMPI, OP_VMULI, OP_VDIVI, OP_VANDI, OP_VORI, OP_VEORI,
			OP_VADDSI, OP_VORSI, OP_VANDSI, OP_VEORSI, OP_VSHIFT, OP_VEC, OP_VECZ};
	endfunction

	function automatic unitT unitFor(opcodeT op);
		if (op inside {OP_MULI, OP_VMULI})
			return UNIT_MUL;
		if (op inside {OP_DIVI, OP_VDIVI})
			return UNIT_DIV;
		if (op == OP_FLT3)
			return UNIT_FPU;
		if (op inside {OP_LDAX, OP_PUSH, OP_POP, OP_ENTER, OP_LEAVE, OP_ATOM})
			return UNIT_MEM;
		if (op inside {OP_BSR, OP_JSR})
			return UNIT_BRANCH;
		if (op inside {OP_SYS, OP_CSR, OP_FENCE, OP_NOP, OP_PFXA32, OP_PFXB32, OP_PFXC32,
			OP_QFEXT, OP_REGC, OP_VEC, OP_VECZ})
			return UNIT_SYS;
		// Whatever else is defined is plain integer work
		if (op inside {OP_R2, OP_MOV, OP_SLTI, OP_SUBFI} || longForm(op) || shortForm(op) ||
			shiftForm(op))
			return UNIT_ALU;
		return UNIT_NONE;
	endfunction

	task automatic modelDecode(input instrT in, output precT prec, output regNumT rd,
		output regNumT rs1, output regNumT rs2, output regNumT rs3, output logic regWrite,
		output immT imm, output logic hasImm, output unitT unit, output logic vector,
		output logic illegal);
		opcodeT                    op;
		logic signed [LIMM_W-1:0]  longVal;
		logic signed [SIMM_W-1:0]  shortVal;
		op       = in[OPC_LSB +: OPC_W];
		longVal  = in[LIMM_LSB +: LIMM_W];
		shortVal = in[SIMM_LSB +: SIMM_W];

		// Precision field position depends on the instruction form
		prec = 2'b11;
		if (op == OP_R2)
			prec = in[PREC_R2_LSB +: PREC_W];
		else if (longForm(op))
			prec = in[PREC_LI_LSB +: PREC_W];
		else if (shortForm(op))
			prec = in[PREC_SI_LSB +: PREC_W];
		else if (shiftForm(op) || op == OP_FLT3)
			prec = in[PREC_SH_LSB +: PREC_W];

		unit    = unitFor(op);
		illegal = (unit == UNIT_NONE);
		vector  = vectorOp(op);

		// Register fields, absent ones read as register 0
		regWrite = op inside {OP_R2, OP_FLT3, OP_MOV, OP_CSR, OP_LDAX} || shiftForm(op) ||
			longForm(op) || shortForm(op);
		regWrite = regWrite && !illegal;
		rd  = regWrite ? in[RD_LSB +: REG_W] : '0;
		rs1 = !regWrite ? '0 : (shortForm(op) ? in[RD_LSB +: REG_W] : in[RS1_LSB +: REG_W]);
		rs2 = (op == OP_R2 || op == OP_FLT3) ? in[RS2_LSB +: REG_W] : '0;
		rs3 = (op == OP_FLT3) ? in[RS3_LSB +: REG_W] : '0;

		// Signed immediates are widened through a signed cast
		imm    = '0;
		hasImm = 1'b1;
		if (longForm(op))
			imm = immT'(longVal);
		else if (shortForm(op))
			imm = immT'(shortVal);
		else if (shiftForm(op))
			imm = immT'(in[SHAMT_LSB +: SHAMT_W]);
		else
			hasImm = 1'b0;
	endtask

	// ==============================
	// Compare tasks
	// ==============================
	task automatic expectPrec(string name, precT got, precT want);
		if (got !== want)
		begin
			errors++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic expectReg(string name, regNumT got, regNumT want);
		if (got !== want)
		begin
			errors++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic expectImm(string name, immT got, immT want);
		if (got !== want)
		begin
			errors++;
			$display("error %s: got 0x%016h expected 0x%016h", name, got, want);
		end
	endtask

	task automatic expectUnit(string name, unitT got, unitT want);
		if (got !== want)
		begin
			errors++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic expectFlag(string name, logic got, logic want);
		if (got !== want)
		begin
			errors++;
			$display("error %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic compareOutputs();
		expectPrec("decPrec", decPrec, expPrec);
		expectReg("decRd", decRd, expRd);
		expectReg("decRs1", decRs1, expRs1);
		expectReg("decRs2", decRs2, expRs2);
		expectReg("decRs3", decRs3, expRs3);
		expectFlag("decRegWrite", decRegWrite, expRegWrite);
		expectImm("decImm", decImm, expImm);
		expectFlag("decHasImm", decHasImm, expHasImm);
		expectUnit("decUnit", decUnit, expUnit);
		expectFlag("decVector", decVector, expVector);
		expectFlag("decIllegal", decIllegal, expIllegal);
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic instrT randInstr(opcodeT op);
		instrT r;
		r[31:0]  = $urandom();
		r[39:32] = 8'($urandom());
		r[OPC_LSB +: OPC_W] = op;
		return r;
	endfunction

	// Present one instruction, wait for decValid and compare every field
	task automatic presentAndCheck(instrT in);
		int waited;
		modelDecode(in, expPrec, expRd, expRs1, expRs2, expRs3, expRegWrite, expImm,
			expHasImm, expUnit, expVector, expIllegal);
		instr      = in;
		instrValid = 1'b1;
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		waited     = 0;
		while (!decValid && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!decValid)
		begin
			errors++;
			$display("Timeout: decValid never rose for instruction 0x%010h", in);
		end
		else
			compareOutputs();
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic resetBehaviour();
		expPrec     = '0;
		expRd       = '0;
		expRs1      = '0;
		expRs2      = '0;
		expRs3      = '0;
		expRegWrite = 1'b0;
		expImm      = '0;
		expHasImm   = 1'b0;
		expUnit     = '0;
		expVector   = 1'b0;
		expIllegal  = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(posedge clk);
			#1;
			expectFlag("decValid", decValid, 1'b0);
			compareOutputs();
			// A strobe in mid reset must not be captured
			instrValid = (i == RESET_CYCLES / 2);
			instr      = randInstr(OP_ADDI);
		end
		instrValid = 1'b0;
		arstN      = 1'b1;
		@(posedge clk);
		#1;
		expectFlag("decValid", decValid, 1'b0);
		compareOutputs();
	endtask

	task automatic precCase(opcodeT op, int lsb);
		instrT in;
		for (int p = 0; p < 4; p++)
		begin
			in = randInstr(op);
			in[lsb +: PREC_W] = precT'(p);
			presentAndCheck(in);
			expectPrec("decPrec", decPrec, precT'(p));
		end
	endtask

	task automatic precisionFields();
		opcodeT plainOps[7];
		plainOps = '{OP_SYS, OP_MOV, OP_LDAX, OP_BSR, OP_PFXA32, OP_VEC, 7'd127};
		precCase(OP_R2, PREC_R2_LSB);
		precCase(OP_ADDI, PREC_LI_LSB);
		precCase(OP_VDIVI, PREC_LI_LSB);
		precCase(OP_SLTI, PREC_LI_LSB);
		precCase(OP_ADDSI, PREC_SI_LSB);
		precCase(OP_VEORSI, PREC_SI_LSB);
		precCase(OP_SHIFT, PREC_SH_LSB);
		precCase(OP_VSHIFT, PREC_SH_LSB);
		precCase(OP_FLT3, PREC_SH_LSB);
		// Forms without a precision field decode as 64 bits
		foreach (plainOps[k])
		begin
			presentAndCheck(randInstr(plainOps[k]));
			expectPrec("decPrec", decPrec, 2'b11);
		end
	endtask

	task automatic regCase(opcodeT op, regNumT wantRd, regNumT wantRs1, regNumT wantRs2,
		regNumT wantRs3, logic wantWrite);
		instrT in;
		in = randInstr(op);
		in[RD_LSB +: REG_W]  = 6'h2A;
		in[RS1_LSB +: REG_W] = 6'h15;
		in[RS2_LSB +: REG_W] = 6'h33;
		in[RS3_LSB +: REG_W] = 6'h0F;
		presentAndCheck(in);
		expectReg("decRd", decRd, wantRd);
		expectReg("decRs1", decRs1, wantRs1);
		expectReg("decRs2", decRs2, wantRs2);
		expectReg("decRs3", decRs3, wantRs3);
		expectFlag("decRegWrite", decRegWrite, wantWrite);
	endtask

	task automatic registerFields();
		regCase(OP_FLT3, 6'h2A, 6'h15, 6'h33, 6'h0F, 1'b1);
		regCase(OP_R2, 6'h2A, 6'h15, 6'h33, 6'h00, 1'b1);
		regCase(OP_MOV, 6'h2A, 6'h15, 6'h00, 6'h00, 1'b1);
		regCase(OP_VCMPI, 6'h2A, 6'h15, 6'h00, 6'h00, 1'b1);
		regCase(OP_SHIFT, 6'h2A, 6'h15, 6'h00, 6'h00, 1'b1);
		// Short forms read rd back as their source
		regCase(OP_VANDSI, 6'h2A, 6'h2A, 6'h00, 6'h00, 1'b1);
		regCase(OP_NOP, 6'h00, 6'h00, 6'h00, 6'h00, 1'b0);
		regCase(OP_BSR, 6'h00, 6'h00, 6'h00, 6'h00, 1'b0);
	endtask

	task automatic immCase(opcodeT op, int lsb, int width, logic [21:0] field, immT want,
		logic wantHas);
		instrT in;
		in = randInstr(op);
		for (int b = 0; b < width; b++)
			in[lsb + b] = field[b];
		presentAndCheck(in);
		expectImm("decImm", decImm, want);
		expectFlag("decHasImm", decHasImm, wantHas);
	endtask

	task automatic immediateExtension();
		immCase(OP_ADDI, LIMM_LSB, LIMM_W, 22'h040000, 64'hFFFF_FFFF_FFFC_0000, 1'b1);
		immCase(OP_SUBFI, LIMM_LSB, LIMM_W, 22'h03ABCD, 64'h0000_0000_0003_ABCD, 1'b1);
		immCase(OP_VORI, LIMM_LSB, LIMM_W, 22'h07FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
		immCase(OP_ORSI, SIMM_LSB, SIMM_W, 22'h200001, 64'hFFFF_FFFF_FFE0_0001, 1'b1);
		immCase(OP_VADDSI, SIMM_LSB, SIMM_W, 22'h1FFFFF, 64'h0000_0000_001F_FFFF, 1'b1);
		immCase(OP_VSHIFT, SHAMT_LSB, SHAMT_W, 22'h00003F, 64'h0000_0000_0000_003F, 1'b1);
		immCase(OP_SHIFT, SHAMT_LSB, SHAMT_W, 22'h000021, 64'h0000_0000_0000_0021, 1'b1);
		immCase(OP_MOV, 0, 0, 22'h000000, 64'h0, 1'b0);
	endtask

	task automatic unitSpot(opcodeT op, unitT want, logic wantVector);
		presentAndCheck(randInstr(op));
		expectUnit("decUnit", decUnit, want);
		expectFlag("decVector", decVector, wantVector);
		expectFlag("decIllegal", decIllegal, 1'b0);
	endtask

	task automatic unitSelection();
		opcodeT op;
		// Full opcode sweep against the model, undefined codes checked directly
		for (int i = 0; i < 128; i++)
		begin
			op = opcodeT'(i);
			presentAndCheck(randInstr(op));
			if (unitFor(op) == UNIT_NONE)
			begin
				expectFlag("decIllegal", decIllegal, 1'b1);
				expectFlag("decRegWrite", decRegWrite, 1'b0);
				expectUnit("decUnit", decUnit, UNIT_NONE);
			end
			else
				legalOps.push_back(op);
		end
		unitSpot(OP_VMULI, UNIT_MUL, 1'b1);
		unitSpot(OP_DIVI, UNIT_DIV, 1'b0);
		unitSpot(OP_FLT3, UNIT_FPU, 1'b0);
		unitSpot(OP_ATOM, UNIT_MEM, 1'b0);
		unitSpot(OP_JSR, UNIT_BRANCH, 1'b0);
		unitSpot(OP_PFXC32, UNIT_SYS, 1'b0);
		unitSpot(OP_VECZ, UNIT_SYS, 1'b1);
		unitSpot(OP_VSHIFT, UNIT_ALU, 1'b1);
	endtask

	// Back-to-back stream; results appear exactly one cycle after each strobe
	task automatic randomStream();
		int     sent;
		logic   lastValid;
		logic   idle;
		instrT  in;
		opcodeT op;
		sent      = 0;
		lastValid = 1'b0;
		while (sent < STREAM_LEN)
		begin
			// Never two idle cycles in a row, so the loop always ends
			idle = lastValid && ($urandom_range(0, 7) == 0);
			if (idle)
				instrValid = 1'b0;
			else
			begin
				if ($urandom_range(0, 1) == 1)
					op = legalOps[$urandom_range(0, legalOps.size() - 1)];
				else
					op = opcodeT'($urandom_range(0, 127));
				in = randInstr(op);
				modelDecode(in, expPrec, expRd, expRs1, expRs2, expRs3, expRegWrite, expImm,
					expHasImm, expUnit, expVector, expIllegal);
				instr      = in;
				instrValid = 1'b1;
				sent++;
			end
			lastValid = !idle;
			@(posedge clk);
			#1;
			expectFlag("decValid", decValid, lastValid);
			compareOutputs();
		end
		instrValid = 1'b0;
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		void'($urandom(32'h8cdb_2ef0));
		errors     = 0;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		resetBehaviour();
		unitSelection();
		precisionFields();
		registerFields();
		immediateExtension();
		randomStream();
		@(posedge clk);
		#1;
		$display("Decode stage run finished with %0d errors", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: flist.f
logic/decodePkg.sv
logic/decodePrec.sv
logic/decodeRegs.sv
logic/decodeImm.sv
logic/decodeUnitSel.sv
logic/decodeStage.sv
testbench/decodeStage_assert.sv
testbench/decodeStageTb.sv

// File: build.sh
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decodeStageTb -f flist.f \
	-o decodeStageSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/decodeStageSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
